// File: hw/arm_settings.svh
`ifndef ARM_SETTINGS_SVH
`define ARM_SETTINGS_SVH

// Data path and register file
`define ARM_XLEN 32
`define ARM_NREGS 16

// Register address bits, log2 of ARM_NREGS
`define ARM_REG_AW 4

// Byte address bits for instruction and data memory
`define ARM_ADDR_W 32

// First fetch address after reset
`define ARM_RESET_PC 32'h0000_0000

`endif

// File: hw/armIsaPkg.sv
`include "arm_settings.svh"

package armIsaPkg;

   // Condition field, bits 31:28
   typedef enum logic [3:0] {
      EQ = 4'b0000, NE, CS, CC,
      MI, PL, VS, VC,
      HI, LS, GE, LT,
      GT, LE, AL
   } condCodeT;

   // Major class, bits 27:26
   typedef enum logic [1:0] {
      classDp = 2'b00,
      classMem = 2'b01,
      classBranch = 2'b10
   } instrClassT;

   // Data-processing opcode, bits 24:21
   typedef enum logic [3:0] {
      AND = 4'b0000,
      SUB = 4'b0010,
      ADD = 4'b0100,
      ORR = 4'b1100
   } dpOpT;

   typedef struct packed {
      condCodeT cond;
      instrClassT op;
      logic imm;                      // 1 for #imm8, 0 for Rm
      dpOpT opcode;
      logic s;                        // Update flags
      logic [`ARM_REG_AW-1:0] rn;
      logic [`ARM_REG_AW-1:0] rd;
      logic [11:0] operand2;          // imm8 or Rm in the low bits
   } dpInstrT;

   typedef struct packed {
      condCodeT cond;
      instrClassT op;
      logic [4:0] funct;
      logic l;                        // 1 for LDR, 0 for STR
      logic [`ARM_REG_AW-1:0] rn;
      logic [`ARM_REG_AW-1:0] rd;
      logic [11:0] offset12;
   } memInstrT;

   // One fetched word, two field layouts
   // Branch offset is raw[23:0]
   typedef union packed {
      dpInstrT dp;
      memInstrT mem;
      logic [`ARM_XLEN-1:0] raw;
   } instrU;

endpackage

// File: hw/armPipePkg.sv
package armPipePkg;

   typedef enum logic [1:0] {
      aluAdd = 2'b00,
      aluSub = 2'b01,
      aluAnd = 2'b10,
      aluOr = 2'b11
   } aluOpT;

   // Same bit order as the CPSR top nibble
   typedef struct packed {
      logic n;
      logic z;
      logic c;
      logic v;
   } flagsT;

   // Control carried from decode into execute
   typedef struct packed {
      aluOpT aluOp;
      logic useImm;                   // Operand B from the immediate
      logic setFlags;                 // S bit
      logic branch;
      logic load;
      logic store;
      logic regWrite;
      armIsaPkg::condCodeT cond;
   } execCtrlT;

endpackage

// File: hw/armStageIf.sv
`include "arm_settings.svh"

// Decode to execute register outputs, branch redirect back
interface decodeExecIf
   import armPipePkg::*;
();
   logic valid;
   execCtrlT ctrl;
   logic [`ARM_XLEN-1:0] operandA;
   logic [`ARM_XLEN-1:0] operandB;
   logic [`ARM_XLEN-1:0] immediate;
   logic [`ARM_REG_AW-1:0] srcRegA;
   logic [`ARM_REG_AW-1:0] srcRegB;
   logic [`ARM_REG_AW-1:0] destReg;
   logic [`ARM_ADDR_W-1:0] pc;
   logic branchTaken;
   logic [`ARM_ADDR_W-1:0] branchTarget;

   modport source (output valid, ctrl, operandA, operandB, immediate,
                   srcRegA, srcRegB, destReg, pc,
                   input branchTaken, branchTarget);
   modport sink (input valid, ctrl, operandA, operandB, immediate,
                 srcRegA, srcRegB, destReg, pc,
                 output branchTaken, branchTarget);
endinterface

// Execute to result, controls already condition gated
interface execResultIf;
   logic valid;
   logic load;
   logic store;
   logic regWrite;
   logic [`ARM_REG_AW-1:0] destReg;
   logic [`ARM_XLEN-1:0] aluResult;
   logic [`ARM_XLEN-1:0] storeData;

   modport source (output valid, load, store, regWrite, destReg, aluResult, storeData);
   modport sink (input valid, load, store, regWrite, destReg, aluResult, storeData);
endinterface

// Register write and pipeline hold from the result stage
interface writeBackIf;
   logic write;
   logic [`ARM_REG_AW-1:0] destReg;
   logic [`ARM_XLEN-1:0] data;
   logic hold;

   modport source (output write, destReg, data, hold);
   modport sink (input write, destReg, data, hold);
endinterface

// File: hw/armDecode.sv
`include "arm_settings.svh"

module armDecode
   import armIsaPkg::*;
   import armPipePkg::*;
(
   input logic clk,
   input logic reset,
   input instrU instr,
   output logic [`ARM_ADDR_W-1:0] pc,
   decodeExecIf.source exec,
   writeBackIf.sink wb
);

   logic [`ARM_XLEN-1:0] regFile [`ARM_NREGS-2:0];   // R0 to R14
   instrU fetchInstr;
   logic fetchValid;
   logic [`ARM_ADDR_W-1:0] fetchPc;
   execCtrlT ctrl;
   logic [`ARM_REG_AW-1:0] regA;
   logic [`ARM_REG_AW-1:0] regB;
   logic [`ARM_XLEN-1:0] readA;
   logic [`ARM_XLEN-1:0] readB;
   logic [`ARM_XLEN-1:0] extImm;
   logic advance;

   assign advance = ~wb.hold;

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
         pc <= `ARM_RESET_PC;
      else if (advance)
         pc <= exec.branchTaken ? exec.branchTarget : pc + 4;
   end

   // Fetch register
   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
         fetchValid <= 1'b0;
      else if (advance)
         fetchValid <= ~exec.branchTaken;   // Wrong-path word dropped
   end

   always_ff @(posedge clk)
   begin
      if (advance)
      begin
         fetchInstr <= instr;
         fetchPc <= pc;
      end
   end

   // Control and immediate from the fetched word
   always_comb
   begin
      ctrl = '0;
      ctrl.cond = fetchInstr.dp.cond;
      extImm = '0;
      case (fetchInstr.dp.op)
         classDp:
         begin
            ctrl.useImm = fetchInstr.dp.imm;
            ctrl.setFlags = fetchInstr.dp.s;
            ctrl.regWrite = 1'b1;
            extImm = {24'b0, fetchInstr.dp.operand2[7:0]};
            case (fetchInstr.dp.opcode)
               ADD: ctrl.aluOp = aluAdd;
               SUB: ctrl.aluOp = aluSub;
               ORR: ctrl.aluOp = aluOr;
               default: ctrl.aluOp = aluAnd;
            endcase
         end
         classMem:
         begin
            ctrl.useImm = 1'b1;             // Address is Rn plus offset
            ctrl.load = fetchInstr.mem.l;
            ctrl.store = ~fetchInstr.mem.l;
            ctrl.regWrite = fetchInstr.mem.l;
            extImm = {20'b0, fetchInstr.mem.offset12};
         end
         classBranch:
         begin
            ctrl.branch = 1'b1;
            extImm = {{6{fetchInstr.raw[23]}}, fetchInstr.raw[23:0], 2'b00};
         end
         default: ctrl.regWrite = 1'b0;   // Unsupported, no effect
      endcase
   end

   assign regA = fetchInstr.dp.rn;
   assign regB = (fetchInstr.dp.op == classMem) ? fetchInstr.mem.rd
                                                : fetchInstr.dp.operand2[`ARM_REG_AW-1:0];

   // Register file, R15 not writable and reads zero
   always_ff @(posedge clk)
   begin
      if (wb.write && wb.destReg != '1)
         regFile[wb.destReg] <= wb.data;
   end

   always_comb
   begin
      readA = (regA == '1) ? '0 : regFile[regA];
      readB = (regB == '1) ? '0 : regFile[regB];
      // Write in this cycle passes straight through
      if (wb.write && wb.destReg == regA)
         readA = wb.data;
      if (wb.write && wb.destReg == regB)
         readB = wb.data;
   end

   // Decode to execute register
   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         exec.valid <= 1'b0;
         exec.ctrl <= '0;
      end
      else if (advance)
      begin
         exec.valid <= fetchValid & ~exec.branchTaken;
         exec.ctrl <= ctrl;
      end
   end

   always_ff @(posedge clk)
   begin
      if (advance)
      begin
         exec.operandA <= readA;
         exec.operandB <= readB;
         exec.immediate <= extImm;
         exec.srcRegA <= regA;
         exec.srcRegB <= regB;
         exec.destReg <= fetchInstr.dp.rd;
         exec.pc <= fetchPc;
      end
   end

endmodule

// File: hw/armExecute.sv
`include "arm_settings.svh"

module armExecute
   import armIsaPkg::*;
   import armPipePkg::*;
(
   input logic clk,
   input logic reset,
   decodeExecIf.sink dec,
   execResultIf.source res,
   writeBackIf.sink wb
);

   localparam int Msb = `ARM_XLEN - 1;

   logic [`ARM_XLEN-1:0] srcA;
   logic [`ARM_XLEN-1:0] regValB;
   logic [`ARM_XLEN-1:0] srcB;
   logic [`ARM_XLEN-1:0] bInv;
   logic [`ARM_XLEN-1:0] result;
   logic [`ARM_XLEN:0] sum;                 // Top bit is the carry out
   logic subtract;
   logic isArith;
   flagsT flags;
   flagsT aluFlags;
   logic signedGe;
   logic condPass;

   // Forward the result stage write
   assign srcA = (wb.write && wb.destReg == dec.srcRegA) ? wb.data : dec.operandA;
   assign regValB = (wb.write && wb.destReg == dec.srcRegB) ? wb.data : dec.operandB;
   assign srcB = dec.ctrl.useImm ? dec.immediate : regValB;

   assign subtract = (dec.ctrl.aluOp == aluSub);
   assign isArith = dec.ctrl.aluOp inside {aluAdd, aluSub};
   assign bInv = subtract ? ~srcB : srcB;
   assign sum = {1'b0, srcA} + {1'b0, bInv} + {{`ARM_XLEN{1'b0}}, subtract};

   always_comb
   begin
      case (dec.ctrl.aluOp)
         aluAnd: result = srcA & srcB;
         aluOr: result = srcA | srcB;
         default: result = sum[Msb:0];
      endcase
   end

   assign aluFlags.n = result[Msb];
   assign aluFlags.z = (result == '0);
   assign aluFlags.c = isArith & sum[`ARM_XLEN];   // Not-borrow on SUB
   assign aluFlags.v = isArith & ~(srcA[Msb] ^ srcB[Msb] ^ subtract) &
                       (srcA[Msb] ^ sum[Msb]);

   // Condition check against the flag register
   assign signedGe = (flags.n == flags.v);

   always_comb
   begin
      case (dec.ctrl.cond)
         EQ: condPass = flags.z;
         NE: condPass = ~flags.z;
         CS: condPass = flags.c;
         CC: condPass = ~flags.c;
         MI: condPass = flags.n;
         PL: condPass = ~flags.n;
         VS: condPass = flags.v;
         VC: condPass = ~flags.v;
         HI: condPass = flags.c & ~flags.z;
         LS: condPass = ~flags.c | flags.z;
         GE: condPass = signedGe;
         LT: condPass = ~signedGe;
         GT: condPass = ~flags.z & signedGe;
         LE: condPass = flags.z | ~signedGe;
         AL: condPass = 1'b1;
         default: condPass = 1'b0;       // 1111 never executes
      endcase
   end

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
         flags <= '0;
      else if (~wb.hold && dec.valid && dec.ctrl.setFlags && condPass)
      begin
         flags.n <= aluFlags.n;
         flags.z <= aluFlags.z;
         if (isArith)                   // Logical ops keep C and V
         begin
            flags.c <= aluFlags.c;
            flags.v <= aluFlags.v;
         end
      end
   end

   assign dec.branchTaken = dec.valid & dec.ctrl.branch & condPass;
   assign dec.branchTarget = dec.pc + 32'd8 + dec.immediate;   // PC+8 relative

   // Result stage qualifies these with valid
   assign res.valid = dec.valid;
   assign res.load = dec.ctrl.load & condPass;
   assign res.store = dec.ctrl.store & condPass;
   assign res.regWrite = dec.ctrl.regWrite & condPass;
   assign res.destReg = dec.destReg;
   assign res.aluResult = result;
   assign res.storeData = regValB;

endmodule

// File: hw/armResult.sv
`include "arm_settings.svh"

module armResult (
   input logic clk,
   input logic reset,
   execResultIf.sink exec,
   writeBackIf.source wb,
   output logic memStrobe,
   output logic memWrite,
   output logic [`ARM_ADDR_W-1:0] memAddr,
   output logic [`ARM_XLEN-1:0] memWriteData,
   input logic [`ARM_XLEN-1:0] memReadData,
   input logic memReady
);

   logic validR;
   logic loadR;
   logic storeR;
   logic regWriteR;
   logic [`ARM_REG_AW-1:0] destR;
   logic [`ARM_XLEN-1:0] aluResultR;
   logic [`ARM_XLEN-1:0] storeDataR;
   logic access;

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         validR <= 1'b0;
         loadR <= 1'b0;
         storeR <= 1'b0;
         regWriteR <= 1'b0;
      end
      else if (~wb.hold)
      begin
         validR <= exec.valid;
         loadR <= exec.load;
         storeR <= exec.store;
         regWriteR <= exec.regWrite;
      end
   end

   // Held stable while the access waits
   always_ff @(posedge clk)
   begin
      if (~wb.hold)
      begin
         destR <= exec.destReg;
         aluResultR <= exec.aluResult;
         storeDataR <= exec.storeData;
      end
   end

   assign access = validR & (loadR | storeR);

   assign memStrobe = access;
   assign memWrite = validR & storeR;
   assign memAddr = aluResultR[`ARM_ADDR_W-1:0];
   assign memWriteData = storeDataR;

   // Whole pipeline waits for ready
   assign wb.hold = access & ~memReady;

   assign wb.write = validR & regWriteR & ~wb.hold;   // Load writes at the ready edge
   assign wb.destReg = destR;
   assign wb.data = loadR ? memReadData : aluResultR;

endmodule

// File: hw/armCore.sv
`include "arm_settings.svh"

module armCore (
   input logic clk,
   input logic reset,
   output logic [`ARM_ADDR_W-1:0] pc,
   input logic [`ARM_XLEN-1:0] instr,
   output logic memStrobe,
   output logic memWrite,
   output logic [`ARM_ADDR_W-1:0] memAddr,
   output logic [`ARM_XLEN-1:0] memWriteData,
   input logic [`ARM_XLEN-1:0] memReadData,
   input logic memReady
);

   decodeExecIf decExec ();
   execResultIf execRes ();
   writeBackIf writeBack ();

   // Fetch register, decode, register file
   armDecode decodeStage (
      .clk(clk),
      .reset(reset),
      .instr(instr),
      .pc(pc),
      .exec(decExec.source),
      .wb(writeBack.sink)
   );

   // ALU, flags, condition, branch
   armExecute executeStage (
      .clk(clk),
      .reset(reset),
      .dec(decExec.sink),
      .res(execRes.source),
      .wb(writeBack.sink)
   );

   armResult resultStage (
      .clk(clk),
      .reset(reset),
      .exec(execRes.sink),
      .wb(writeBack.source),
      .memStrobe(memStrobe),
      .memWrite(memWrite),
      .memAddr(memAddr),
      .memWriteData(memWriteData),
      .memReadData(memReadData),
      .memReady(memReady)
   );

endmodule

// File: verif/armCore_properties.sv
`include "arm_settings.svh"

module armCoreProperties (
   input logic clk,
   input logic reset,
   input logic [`ARM_ADDR_W-1:0] pc,
   input logic memStrobe,
   input logic memWrite,
   input logic [`ARM_ADDR_W-1:0] memAddr,
   input logic [`ARM_XLEN-1:0] memWriteData,
   input logic memReady
);
   timeunit 1ns;
   timeprecision 100ps;

   int failCount = 0;   // Count of failed assertions

   // Idle bus and reset PC through reset and in the first cycle after it
   resetState: assert property (@(posedge clk)
         reset |=> !memStrobe && pc == `ARM_RESET_PC)
      else
      begin
         failCount++;
         $error("memStrobe or pc not at the reset state around reset");
      end

   // Request held steady while waiting for ready
   requestStable: assert property (@(posedge clk) disable iff (reset)
         memStrobe && !memReady |=> memStrobe && $stable(memWrite) && $stable(memAddr)
            && $stable(memWriteData))
      else
      begin
         failCount++;
         $error("memory request dropped or changed before memReady");
      end

   pcStable: assert property (@(posedge clk) disable iff (reset)
         memStrobe && !memReady |=> $stable(pc))
      else
      begin
         failCount++;
         $error("pc moved while the pipeline waits for memReady");
      end

endmodule

bind armCore armCoreProperties props (.*);

// File: verif/tb_armCore.sv
`include "arm_settings.svh"

module tb_armCore
   import armIsaPkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int ClkPeriod = 40;
   localparam int WorstWait = 16;   // Longest zero run of the LFSR plus one
   localparam int NumTests = 5;

   logic clk;
   logic reset;
   logic [`ARM_ADDR_W-1:0] pc;
   logic [`ARM_XLEN-1:0] instr;
   logic memStrobe;
   logic memWrite;
   logic [`ARM_ADDR_W-1:0] memAddr;
   logic [`ARM_XLEN-1:0] memWriteData;
   logic [`ARM_XLEN-1:0] memReadData;
   logic memReady;
   logic storeDone;
   logic [15:0] lfsr;
   logic [31:0] imem [64];
   logic [31:0] dmem [64];
   logic [31:0] expAddr [48];
   logic [31:0] expData [48];
   logic [31:0] wantAddr;
   logic [31:0] wantData;
   int instrTest [64];
   int testEnd [NumTests];
   int progLen;
   int curTest;
   int expCount;
   int storeCount;
   int waitCycles;
   int errors;
   int neverFetch;
   string testName [NumTests] = '{"reset", "alu", "condition", "load-use", "branch"};

   armCore dut (
      .clk(clk),
      .reset(reset),
      .pc(pc),
      .instr(instr),
      .memStrobe(memStrobe),
      .memWrite(memWrite),
      .memAddr(memAddr),
      .memWriteData(memWriteData),
      .memReadData(memReadData),
      .memReady(memReady)
   );

   always #(ClkPeriod / 2) clk = ~clk;

   assign instr = imem[pc[7:2]];             // Combinational fetch
   assign memReadData = dmem[memAddr[7:2]];
   assign storeDone = memStrobe && memWrite && memReady;
   assign wantAddr = expAddr[storeCount];
   assign wantData = expData[storeCount];

   function automatic logic [15:0] lfsrStep(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   function automatic logic [31:0] dpWord(input condCodeT cond, input dpOpT opc,
                                          input logic s, input int rd, input int rn,
                                          input logic imm, input logic [7:0] op2);
      return {cond, 2'b00, imm, opc, s, rn[3:0], rd[3:0], 4'b0000, op2};
   endfunction

   function automatic logic [31:0] memWord(input condCodeT cond, input logic load,
                                           input int rd, input int rn, input logic [11:0] off);
      return {cond, 2'b01, 5'b01100, load, rn[3:0], rd[3:0], off};
   endfunction

   function automatic logic [31:0] branchWord(input condCodeT cond, input int off);
      return {cond, 4'b1010, off[23:0]};
   endfunction

   // ARM condition table
   function automatic logic condHolds(input logic [3:0] cond, input logic n, input logic z,
                                      input logic c, input logic v);
      case (cond)
         EQ: return z;
         NE: return !z;
         CS: return c;
         CC: return !c;
         MI: return n;
         PL: return !n;
         VS: return v;
         VC: return !v;
         HI: return c && !z;
         LS: return !c || z;
         GE: return n == v;
         LT: return n != v;
         GT: return !z && n == v;
         LE: return z || n != v;
         default: return cond == AL;
      endcase
   endfunction

   task automatic appendInstr(input logic [31:0] word);
      imem[progLen] = word;
      instrTest[progLen] = curTest;
      progLen++;
   endtask

   task automatic loadProgram();
      int i;
      for (i = 0; i < 64; i++)
         imem[i] = dpWord(AL, AND, 0, 14, 14, 1, 8'(i));   // Filler, never reached
      progLen = 0;
      curTest = 1;
      appendInstr(dpWord(AL, ADD, 0, 0, 15, 1, 8'h40));    // Base address, R15 reads zero
      appendInstr(memWord(AL, 1, 1, 0, 12'h000));
      appendInstr(memWord(AL, 1, 2, 0, 12'h004));
      appendInstr(dpWord(AL, ADD, 0, 3, 1, 0, 8'd2));      // Uses the load just before
      appendInstr(dpWord(AL, SUB, 0, 4, 3, 1, 8'd5));
      appendInstr(dpWord(AL, AND, 0, 5, 4, 0, 8'd1));
      appendInstr(dpWord(AL, ORR, 0, 6, 5, 1, 8'h81));
      appendInstr(dpWord(AL, AND, 0, 11, 6, 1, 8'h3C));
      appendInstr(dpWord(AL, ORR, 0, 12, 11, 0, 8'd4));
      for (i = 0; i < 5; i++)
         appendInstr(memWord(AL, 0, (i == 4) ? 12 : i + 3, 0, 12'(12'h040 + 4 * i)));
      curTest = 2;
      appendInstr(dpWord(AL, SUB, 1, 7, 1, 0, 8'd1));      // Equal operands
      appendInstr(memWord(EQ, 0, 1, 0, 12'h054));
      appendInstr(memWord(NE, 0, 2, 0, 12'h058));
      appendInstr(dpWord(AL, SUB, 1, 7, 1, 0, 8'd2));      // R1 above R2
      appendInstr(memWord(GT, 0, 1, 0, 12'h05C));
      appendInstr(memWord(LT, 0, 2, 0, 12'h060));
      appendInstr(dpWord(AL, SUB, 1, 7, 2, 0, 8'd1));      // R2 below R1
      appendInstr(memWord(GE, 0, 3, 0, 12'h064));
      appendInstr(memWord(LE, 0, 4, 0, 12'h068));
      appendInstr(memWord(HI, 0, 5, 0, 12'h06C));
      appendInstr(memWord(LS, 0, 6, 0, 12'h070));
      curTest = 3;
      appendInstr(memWord(AL, 1, 9, 0, 12'h008));
      appendInstr(dpWord(AL, ADD, 0, 10, 9, 0, 8'd1));
      appendInstr(memWord(AL, 0, 10, 0, 12'h074));
      curTest = 4;
      neverFetch = (progLen + 3) * 4;   // Past the two discarded words
      appendInstr(branchWord(AL, 3));
      for (i = 0; i < 4; i++)
         appendInstr(memWord(AL, 0, i + 1, 0, 12'(12'h078 + 4 * i)));
      appendInstr(branchWord(EQ, 0));   // Flags still unequal
      appendInstr(memWord(AL, 0, 9, 0, 12'h088));
      appendInstr(branchWord(AL, -2));  // Parks the core
   endtask

   // Instruction-level model of the program from the ARM rules
   task automatic runModel();
      logic [31:0] r [16];
      logic [31:0] mdm [64];
      logic [31:0] w;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic [31:0] addr;
      logic n, z, c, v;
      int p;
      int t;
      int perTest [NumTests];
      r = '{default: '0};
      mdm = dmem;
      perTest = '{default: 0};
      {n, z, c, v} = 4'b0000;
      p = 0;
      expCount = 0;
      for (int step = 0; step < 200; step++)
      begin
         w = imem[p];
         if (w[27:24] == 4'b1010 && w[23:0] == 24'hFF_FFFE)
            break;
         if (!condHolds(w[31:28], n, z, c, v))
            p++;
         else if (w[27:26] == 2'b10)
            p = p + 2 + $signed(w[23:0]);                  // pc + 8 + offset * 4
         else if (w[27:26] == 2'b01)
         begin
            addr = r[w[19:16]] + {20'b0, w[11:0]};
            if (w[20])
               r[w[15:12]] = mdm[addr[7:2]];
            else
            begin
               mdm[addr[7:2]] = r[w[15:12]];
               expAddr[expCount] = addr;
               expData[expCount] = r[w[15:12]];
               expCount++;
               perTest[instrTest[p]]++;
            end
            p++;
         end
         else
         begin
            a = r[w[19:16]];
            b = w[25] ? {24'b0, w[7:0]} : r[w[3:0]];
            case (w[24:21])
               ADD: res = a + b;
               SUB: res = a - b;
               AND: res = a & b;
               default: res = a | b;
            endcase
            if (w[20])
            begin
               n = res[31];
               z = (res == 0);
               if (w[24:21] == ADD)
               begin
                  c = (res < a);                          // Unsigned wrap
                  v = (a[31] == b[31]) && (res[31] != a[31]);
               end
               else if (w[24:21] == SUB)
               begin
                  c = (a >= b);                           // No borrow
                  v = (a[31] != b[31]) && (res[31] != a[31]);
               end
            end
            if (w[15:12] != 4'hF)
               r[w[15:12]] = res;
            p++;
         end
      end
      testEnd[0] = 0;
      for (t = 1; t < NumTests; t++)
         testEnd[t] = testEnd[t - 1] + perTest[t];
   endtask

   // Ready pattern, one LFSR bit per cycle
   always @(posedge clk)
   begin
      memReady <= lfsr[0];
      lfsr <= lfsrStep(lfsr);
   end

   always @(posedge clk)
   begin
      if (!reset && storeDone)
      begin
         dmem[memAddr[7:2]] <= memWriteData;
         storeCount <= storeCount + 1;
      end
      if (!reset && memStrobe && !memReady)
         waitCycles <= waitCycles + 1;
   end

   storeExpected: assert property (@(posedge clk) disable iff (reset)
         storeDone |-> storeCount < expCount)
      else
      begin
         errors++;
         $display("Store to %h that the program never makes", $sampled(memAddr));
      end

   storeAddr: assert property (@(posedge clk) disable iff (reset)
         storeDone && storeCount < expCount |-> memAddr == wantAddr)
      else
      begin
         errors++;
         $display("[ERROR] memAddr = %h, expected %h", $sampled(memAddr), $sampled(wantAddr));
      end

   storeData: assert property (@(posedge clk) disable iff (reset)
         storeDone && storeCount < expCount |-> memWriteData == wantData)
      else
      begin
         errors++;
         $display("[ERROR] memWriteData = %h, expected %h", $sampled(memWriteData),
                  $sampled(wantData));
      end

   skippedFetch: assert property (@(posedge clk) disable iff (reset)
         pc != neverFetch && pc != neverFetch + 4)
      else
      begin
         errors++;
         $display("pc reached an address that the taken branch jumps over");
      end

   initial
   begin
      @(negedge reset);
      #(4 * progLen * WorstWait * ClkPeriod);
      $display("Timeout: the program did not finish its stores in time");
      $display("Testbench failed");
      $finish;
   end

   initial
   begin
      int i;
      int t;
      int errBefore;
      int total;
      clk = 1'b0;
      reset = 1'b1;
      memReady = 1'b0;
      lfsr = 16'd97;
      storeCount = 0;
      waitCycles = 0;
      errors = 0;
      for (i = 0; i < 64; i++)
         dmem[i] = (32'(i) * 32'h9E37_79B1) ^ 32'h0000_1234;
      loadProgram();
      runModel();
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      for (t = 0; t < NumTests; t++)
      begin
         errBefore = errors + dut.props.failCount;
         if (t == 0)
            repeat (2) @(posedge clk);
         else
            wait (storeCount >= testEnd[t]);
         @(negedge clk);   // Let assertion actions of this edge finish
         $display("Test %s: %0d stores so far, %0d errors", testName[t], storeCount,
                  errors + dut.props.failCount - errBefore);
      end
      repeat (20) @(posedge clk);   // Stray late stores still get caught
      @(negedge clk);
      $display("Test handshake: %0d wait cycles, %0d protocol errors", waitCycles,
               dut.props.failCount);
      total = errors + dut.props.failCount;
      $display("Summary: %0d tests, %0d of %0d stores, %0d errors", NumTests + 1, storeCount,
               expCount, total);
      if (total == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

// File: filelist.f
+incdir+hw
hw/armIsaPkg.sv
hw/armPipePkg.sv
hw/armStageIf.sv
hw/armDecode.sv
hw/armExecute.sv
hw/armResult.sv
hw/armCore.sv
verif/armCore_properties.sv
verif/tb_armCore.sv

// File: Bender.yml
package:
  name: arm_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/armIsaPkg.sv
      - hw/armPipePkg.sv
      - hw/armStageIf.sv
      - hw/armDecode.sv
      - hw/armExecute.sv
      - hw/armResult.sv
      - hw/armCore.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/armCore_properties.sv
      - verif/tb_armCore.sv
